//--- verilog/id_pkg.sv
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // link register for jal
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;

    // primary opcodes that are decoded
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_REGIMM  = 6'h01,
        OPC_J       = 6'h02,
        OPC_JAL     = 6'h03,
        OPC_BEQ     = 6'h04,
        OPC_BNE     = 6'h05,
        OPC_BLEZ    = 6'h06,
        OPC_BGTZ    = 6'h07,
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0a,
        OPC_SLTIU   = 6'h0b,
        OPC_ANDI    = 6'h0c,
        OPC_ORI     = 6'h0d,
        OPC_XORI    = 6'h0e,
        OPC_LUI     = 6'h0f,
        OPC_LW      = 6'h23,
        OPC_SW      = 6'h2b
    } opcode_e;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [2:0] {
        ALU_NOP   = 3'b000,
        ALU_ARITH = 3'b001,
        ALU_LOGIC = 3'b010,
        ALU_SHIFT = 3'b100,
        ALU_JUMP  = 3'b101
    } alu_type_e;

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00, OP_LUI   = 8'h05, OP_SLL   = 8'h11, OP_SRL   = 8'h12,
        OP_SRA   = 8'h13, OP_ADDIU = 8'h19, OP_SUBU  = 8'h1b, OP_AND   = 8'h1c,
        OP_ORI   = 8'h1d, OP_XOR   = 8'h1e, OP_NOR   = 8'h1f, OP_SLT   = 8'h26,
        OP_SLTIU = 8'h27, OP_SLTI  = 8'h28, OP_SLTU  = 8'h29, OP_J     = 8'h2c,
        OP_JR    = 8'h2d, OP_JAL   = 8'h2e, OP_JALR  = 8'h2f, OP_BEQ   = 8'h30,
        OP_BNE   = 8'h31, OP_BLEZ  = 8'h32, OP_BGTZ  = 8'h33, OP_BLTZ  = 8'h34,
        OP_BGEZ  = 8'h39, OP_ADDU  = 8'h49, OP_ANDI  = 8'h4c, OP_OR    = 8'h4d,
        OP_XORI  = 8'h4e, OP_LW    = 8'h92, OP_SW    = 8'h9a
    } alu_op_e;

    // next-pc source for fetch
    typedef enum logic [1:0] {
        JS_SEQ = 2'b00,
        JS_REG = 2'b01,
        JS_ABS = 2'b10,
        JS_BR  = 2'b11
    } jump_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } br_kind_e;

    typedef enum logic [1:0] {
        JMP_NONE, JMP_ABS, JMP_REG
    } jmp_kind_e;

    typedef struct packed {
        alu_type_e             alu_type;
        alu_op_e               alu_op;
        logic                  wreg;
        logic                  mreg;
        logic                  smem;
        logic                  rreg1;
        logic                  rreg2;
        logic                  shift;
        logic                  immsel;
        logic                  sext;
        logic                  upper;
        logic                  link;
        logic [REG_ADDR_W-1:0] wa;
        br_kind_e              br_kind;
        jmp_kind_e             jmp_kind;
    } id_ctrl_t;

    // write-back hint from a later stage
    typedef struct packed {
        logic                  wreg;
        logic                  mreg;
        logic [REG_ADDR_W-1:0] wa;
        logic [DATA_W-1:0]     wd;
    } fwd_t;

    typedef struct packed {
        alu_type_e             alu_type;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] wa;
        logic                  wreg;
        logic                  mreg;
        logic [DATA_W-1:0]     src1;
        logic [DATA_W-1:0]     src2;
        logic [DATA_W-1:0]     din;
        logic [DATA_W-1:0]     retaddr;
    } exe_bus_t;

endpackage

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [id_pkg::DATA_W-1:0]     inst_i,
    output id_pkg::id_ctrl_t              ctrl_o,
    output logic [id_pkg::REG_ADDR_W-1:0] rs_o,
    output logic [id_pkg::REG_ADDR_W-1:0] rt_o,
    output logic [15:0]                   imm_o,
    output logic [25:0]                   index_o,
    output logic [4:0]                    sa_o
);
    import id_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               op;
    logic                  is_alu_reg;
    logic                  is_alu_imm;
    logic                  is_shift;
    logic                  is_logic;
    logic                  is_branch;
    logic                  is_jump;
    logic                  is_load;
    logic                  is_store;

    assign opcode  = opcode_e'(inst_i[31:26]);
    assign funct   = funct_e'(inst_i[5:0]);
    assign rs_o    = inst_i[25:21];
    assign rt_o    = inst_i[20:16];
    assign rd      = inst_i[15:11];
    assign sa_o    = inst_i[10:6];
    assign imm_o   = inst_i[15:0];
    assign index_o = inst_i[25:0];

    // recognize the instruction, OP_NOP if not one of ours
    always_comb begin
        op = OP_NOP;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_SLL:  op = OP_SLL;
                    FN_SRL:  op = OP_SRL;
                    FN_SRA:  op = OP_SRA;
                    FN_JR:   op = OP_JR;
                    FN_JALR: op = OP_JALR;
                    FN_ADDU: op = OP_ADDU;
                    FN_SUBU: op = OP_SUBU;
                    FN_AND:  op = OP_AND;
                    FN_OR:   op = OP_OR;
                    FN_XOR:  op = OP_XOR;
                    FN_NOR:  op = OP_NOR;
                    FN_SLT:  op = OP_SLT;
                    FN_SLTU: op = OP_SLTU;
                    default: op = OP_NOP;
                endcase
            end
            // rt selects the compare for REGIMM
            OPC_REGIMM: begin
                if (rt_o == 5'd0)
                    op = OP_BLTZ;
                else if (rt_o == 5'd1)
                    op = OP_BGEZ;
            end
            OPC_J:     op = OP_J;
            OPC_JAL:   op = OP_JAL;
            OPC_BEQ:   op = OP_BEQ;
            OPC_BNE:   op = OP_BNE;
            OPC_BLEZ:  op = OP_BLEZ;
            OPC_BGTZ:  op = OP_BGTZ;
            OPC_ADDIU: op = OP_ADDIU;
            OPC_SLTI:  op = OP_SLTI;
            OPC_SLTIU: op = OP_SLTIU;
            OPC_ANDI:  op = OP_ANDI;
            OPC_ORI:   op = OP_ORI;
            OPC_XORI:  op = OP_XORI;
            OPC_LUI:   op = OP_LUI;
            OPC_LW:    op = OP_LW;
            OPC_SW:    op = OP_SW;
            default:   op = OP_NOP;
        endcase
    end

    assign is_alu_reg = op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
                                   OP_SLT, OP_SLTU};
    assign is_alu_imm = op inside {OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                   OP_SLTI, OP_SLTIU};
    assign is_shift   = op inside {OP_SLL, OP_SRL, OP_SRA};
    assign is_logic   = op inside {OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ANDI, OP_ORI,
                                   OP_XORI, OP_LUI};
    assign is_branch  = op inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_BGEZ, OP_BLTZ};
    assign is_jump    = op inside {OP_J, OP_JAL, OP_JR, OP_JALR};
    assign is_load    = (op == OP_LW);
    assign is_store   = (op == OP_SW);

    always_comb begin
        ctrl_o = '0;
        if (op != OP_NOP) begin
            if (is_shift)
                ctrl_o.alu_type = ALU_SHIFT;
            else if (is_logic)
                ctrl_o.alu_type = ALU_LOGIC;
            else if (is_branch || is_jump)
                ctrl_o.alu_type = ALU_JUMP;
            else
                ctrl_o.alu_type = ALU_ARITH;
            ctrl_o.alu_op = op;
            ctrl_o.wreg   = is_alu_reg || is_alu_imm || is_shift || is_load ||
                            op == OP_JAL || op == OP_JALR;
            ctrl_o.mreg   = is_load;
            ctrl_o.smem   = is_store;
            ctrl_o.rreg1  = is_alu_reg || (is_alu_imm && op != OP_LUI) || is_load ||
                            is_store || is_branch || op == OP_JR || op == OP_JALR;
            ctrl_o.rreg2  = is_alu_reg || is_shift || is_store || op == OP_BEQ ||
                            op == OP_BNE;
            ctrl_o.shift  = is_shift;
            ctrl_o.immsel = is_alu_imm || is_load || is_store;
            ctrl_o.sext   = op inside {OP_ADDIU, OP_SLTI, OP_SLTIU} || is_load || is_store;
            ctrl_o.upper  = (op == OP_LUI);
            ctrl_o.link   = (op == OP_JAL) || (op == OP_JALR);
            if (op == OP_JAL)
                ctrl_o.wa = RA_REG;
            else if (is_alu_imm || is_load || is_store)
                ctrl_o.wa = rt_o;
            else
                ctrl_o.wa = rd;
            case (op)
                OP_BEQ:  ctrl_o.br_kind = BR_EQ;
                OP_BNE:  ctrl_o.br_kind = BR_NE;
                OP_BGTZ: ctrl_o.br_kind = BR_GTZ;
                OP_BLEZ: ctrl_o.br_kind = BR_LEZ;
                OP_BGEZ: ctrl_o.br_kind = BR_GEZ;
                OP_BLTZ: ctrl_o.br_kind = BR_LTZ;
                default: ctrl_o.br_kind = BR_NONE;
            endcase
            if (op == OP_J || op == OP_JAL)
                ctrl_o.jmp_kind = JMP_ABS;
            else if (op == OP_JR || op == OP_JALR)
                ctrl_o.jmp_kind = JMP_REG;
        end
    end

    // lui takes no register operand
    always_comb begin
        assert final (!(ctrl_o.rreg1 && ctrl_o.upper))
            else $error("rreg1 set together with upper");
    end

endmodule

//--- verilog/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  id_pkg::id_ctrl_t              ctrl_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rs_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rt_i,
    input  logic [15:0]                   imm_i,
    input  logic [4:0]                    sa_i,
    input  logic [id_pkg::DATA_W-1:0]     rd1_i,
    input  logic [id_pkg::DATA_W-1:0]     rd2_i,
    input  id_pkg::fwd_t                  exe_fwd_i,
    input  id_pkg::fwd_t                  mem_fwd_i,
    output logic [id_pkg::DATA_W-1:0]     src1_o,
    output logic [id_pkg::DATA_W-1:0]     src2_o,
    output logic [id_pkg::DATA_W-1:0]     din_o,
    output logic                          stall_o
);
    import id_pkg::*;

    logic              exe_hit1;
    logic              exe_hit2;
    logic              mem_hit1;
    logic              mem_hit2;
    logic [DATA_W-1:0] fwd1;
    logic [DATA_W-1:0] fwd2;
    logic [DATA_W-1:0] imm_ext;

    assign exe_hit1 = exe_fwd_i.wreg && (exe_fwd_i.wa == rs_i);
    assign exe_hit2 = exe_fwd_i.wreg && (exe_fwd_i.wa == rt_i);
    assign mem_hit1 = mem_fwd_i.wreg && (mem_fwd_i.wa == rs_i);
    assign mem_hit2 = mem_fwd_i.wreg && (mem_fwd_i.wa == rt_i);

    // execute holds the younger result, so it wins
    assign fwd1 = exe_hit1 ? exe_fwd_i.wd : (mem_hit1 ? mem_fwd_i.wd : rd1_i);
    assign fwd2 = exe_hit2 ? exe_fwd_i.wd : (mem_hit2 ? mem_fwd_i.wd : rd2_i);

    always_comb begin
        if (ctrl_i.upper)
            imm_ext = {imm_i, 16'h0000};
        else if (ctrl_i.sext)
            imm_ext = {{(DATA_W-16){imm_i[15]}}, imm_i};
        else
            imm_ext = {{(DATA_W-16){1'b0}}, imm_i};
    end

    always_comb begin
        if (ctrl_i.shift)
            src1_o = {{(DATA_W-5){1'b0}}, sa_i};
        else if (!ctrl_i.rreg1)
            src1_o = '0;
        else
            src1_o = fwd1;
    end

    always_comb begin
        if (ctrl_i.immsel)
            src2_o = imm_ext;
        else if (!ctrl_i.rreg2)
            src2_o = '0;
        else
            src2_o = fwd2;
    end

    // store data is rt through the same bypass
    assign din_o = ctrl_i.smem ? fwd2 : '0;

    // load result not ready yet
    assign stall_o = (exe_fwd_i.mreg && ((exe_hit1 && ctrl_i.rreg1) ||
                                         (exe_hit2 && ctrl_i.rreg2))) ||
                     (mem_fwd_i.mreg && ((mem_hit1 && ctrl_i.rreg1) ||
                                         (mem_hit2 && ctrl_i.rreg2)));

    always_comb begin
        assert final (!stall_o || ctrl_i.rreg1 || ctrl_i.rreg2)
            else $error("stall raised with no register read");
    end

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::id_ctrl_t          ctrl_i,
    input  logic [id_pkg::DATA_W-1:0] pc_i,
    input  logic [15:0]               imm_i,
    input  logic [25:0]               index_i,
    input  logic [id_pkg::DATA_W-1:0] src1_i,
    input  logic [id_pkg::DATA_W-1:0] src2_i,
    output id_pkg::jump_sel_e         jtsel_o,
    output logic [id_pkg::DATA_W-1:0] addr1_o,
    output logic [id_pkg::DATA_W-1:0] addr2_o,
    output logic [id_pkg::DATA_W-1:0] addr3_o,
    output logic [id_pkg::DATA_W-1:0] retaddr_o
);
    import id_pkg::*;

    logic [DATA_W-1:0] pc_plus4;
    logic              taken;

    assign pc_plus4 = pc_i + DATA_W'(4);

    // compares against zero are signed
    always_comb begin
        case (ctrl_i.br_kind)
            BR_EQ:   taken = (src1_i == src2_i);
            BR_NE:   taken = (src1_i != src2_i);
            BR_GTZ:  taken = !src1_i[DATA_W-1] && (src1_i != '0);
            BR_LEZ:  taken = src1_i[DATA_W-1] || (src1_i == '0);
            BR_GEZ:  taken = !src1_i[DATA_W-1];
            BR_LTZ:  taken = src1_i[DATA_W-1];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl_i.jmp_kind == JMP_ABS)
            jtsel_o = JS_ABS;
        else if (ctrl_i.jmp_kind == JMP_REG)
            jtsel_o = JS_REG;
        else if (taken)
            jtsel_o = JS_BR;
        else
            jtsel_o = JS_SEQ;
    end

    // region jump keeps the top nibble of pc+4
    assign addr1_o   = {pc_plus4[DATA_W-1 -: 4], index_i, 2'b00};
    assign addr2_o   = pc_plus4 + {{(DATA_W-18){imm_i[15]}}, imm_i, 2'b00};
    assign addr3_o   = src1_i;
    assign retaddr_o = pc_i + DATA_W'(8);

endmodule

//--- verilog/id_exe_reg.sv
`timescale 1ns/1ps

module id_exe_reg (
    input  logic                      cpu_clk_i,
    input  logic                      arst_n_i,
    input  logic                      stall_i,
    input  id_pkg::id_ctrl_t          ctrl_i,
    input  logic [id_pkg::DATA_W-1:0] src1_i,
    input  logic [id_pkg::DATA_W-1:0] src2_i,
    input  logic [id_pkg::DATA_W-1:0] din_i,
    input  logic [id_pkg::DATA_W-1:0] retaddr_i,
    output id_pkg::exe_bus_t          exe_o
);
    import id_pkg::*;

    exe_bus_t next_bus;

    // bubble is the all-zero bundle
    always_comb begin
        next_bus = '0;
        if (!stall_i) begin
            next_bus.alu_type = ctrl_i.alu_type;
            next_bus.alu_op   = ctrl_i.alu_op;
            next_bus.wa       = ctrl_i.wa;
            next_bus.wreg     = ctrl_i.wreg;
            next_bus.mreg     = ctrl_i.mreg;
            next_bus.src1     = src1_i;
            next_bus.src2     = src2_i;
            next_bus.din      = din_i;
            // return address only matters for jal/jalr
            next_bus.retaddr  = ctrl_i.link ? retaddr_i : '0;
        end
    end

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            exe_o <= '0;
        else
            exe_o <= next_bus;
    end

    // stalled cycle must not write back in execute
    assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
                     stall_i |=> !exe_o.wreg)
        else $error("bubble after stall writes a register");

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                          cpu_clk_i,
    input  logic                          arst_n_i,
    input  logic [id_pkg::DATA_W-1:0]     id_pc_i,
    input  logic [id_pkg::DATA_W-1:0]     id_inst_i,
    input  logic [id_pkg::DATA_W-1:0]     rd1_i,
    input  logic [id_pkg::DATA_W-1:0]     rd2_i,
    output logic [id_pkg::REG_ADDR_W-1:0] ra1_o,
    output logic [id_pkg::REG_ADDR_W-1:0] ra2_o,
    output logic                          rreg1_o,
    output logic                          rreg2_o,
    input  id_pkg::fwd_t                  exe_fwd_i,
    input  id_pkg::fwd_t                  mem_fwd_i,
    output id_pkg::exe_bus_t              exe_o,
    output id_pkg::jump_sel_e             jtsel_o,
    output logic [id_pkg::DATA_W-1:0]     addr1_o,
    output logic [id_pkg::DATA_W-1:0]     addr2_o,
    output logic [id_pkg::DATA_W-1:0]     addr3_o,
    output logic                          stall_o
);
    import id_pkg::*;

    id_ctrl_t              ctrl;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [15:0]           imm;
    logic [25:0]           index;
    logic [4:0]            sa;
    logic [DATA_W-1:0]     src1;
    logic [DATA_W-1:0]     src2;
    logic [DATA_W-1:0]     din;
    logic [DATA_W-1:0]     retaddr;

    assign ra1_o   = rs;
    assign ra2_o   = rt;
    assign rreg1_o = ctrl.rreg1;
    assign rreg2_o = ctrl.rreg2;

    inst_decoder i_decoder (
        .inst_i  (id_inst_i),
        .ctrl_o  (ctrl),
        .rs_o    (rs),
        .rt_o    (rt),
        .imm_o   (imm),
        .index_o (index),
        .sa_o    (sa)
    );

    operand_select i_operand (
        .ctrl_i    (ctrl),
        .rs_i      (rs),
        .rt_i      (rt),
        .imm_i     (imm),
        .sa_i      (sa),
        .rd1_i     (rd1_i),
        .rd2_i     (rd2_i),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .src1_o    (src1),
        .src2_o    (src2),
        .din_o     (din),
        .stall_o   (stall_o)
    );

    branch_unit i_branch (
        .ctrl_i    (ctrl),
        .pc_i      (id_pc_i),
        .imm_i     (imm),
        .index_i   (index),
        .src1_i    (src1),
        .src2_i    (src2),
        .jtsel_o   (jtsel_o),
        .addr1_o   (addr1_o),
        .addr2_o   (addr2_o),
        .addr3_o   (addr3_o),
        .retaddr_o (retaddr)
    );

    id_exe_reg i_exe_reg (
        .cpu_clk_i (cpu_clk_i),
        .arst_n_i  (arst_n_i),
        .stall_i   (stall_o),
        .ctrl_i    (ctrl),
        .src1_i    (src1),
        .src2_i    (src2),
        .din_i     (din),
        .retaddr_i (retaddr),
        .exe_o     (exe_o)
    );

endmodule

//--- tests/tb_vectors.svh
// columns: name, inst, pc, exe fwd, mem fwd, random fill, stall, jtsel,
// target select (0 none, 1..3 addr1..addr3), target, read enables {rs, rt}, exe bundle
task automatic load_vectors();
    add_row("addu", r_type(1, 2, 3, 0, FN_ADDU), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_ADDU, 3, 1, 0, rv(1), rv(2), 0, 0));
    add_row("subu", r_type(5, 6, 4, 0, FN_SUBU), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_SUBU, 4, 1, 0, rv(5), rv(6), 0, 0));
    add_row("nor", r_type(8, 9, 7, 0, FN_NOR), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_LOGIC, OP_NOR, 7, 1, 0, rv(8), rv(9), 0, 0));
    add_row("sltu", r_type(11, 12, 10, 0, FN_SLTU), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_SLTU, 10, 1, 0, rv(11), rv(12), 0, 0));
    add_row("addiu", i_type(OPC_ADDIU, 14, 13, 16'hfffc), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ,
            0, 0, 2'b10, mk_exe(ALU_ARITH, OP_ADDIU, 13, 1, 0, rv(14), 32'hfffffffc, 0, 0));
    add_row("ori", i_type(OPC_ORI, 16, 15, 16'h8001), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b10, mk_exe(ALU_LOGIC, OP_ORI, 15, 1, 0, rv(16), 32'h00008001, 0, 0));
    add_row("lui", i_type(OPC_LUI, 0, 17, 16'h1234), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b00, mk_exe(ALU_LOGIC, OP_LUI, 17, 1, 0, 0, 32'h12340000, 0, 0));
    add_row("slti", i_type(OPC_SLTI, 19, 18, 16'h8000), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b10, mk_exe(ALU_ARITH, OP_SLTI, 18, 1, 0, rv(19), 32'hffff8000, 0, 0));
    add_row("sra", r_type(0, 21, 20, 7, FN_SRA), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b01, mk_exe(ALU_SHIFT, OP_SRA, 20, 1, 0, 7, rv(21), 0, 0));
    add_row("fwd exe over mem", r_type(1, 2, 3, 0, FN_ADDU), PC0, fwd(1, 0, 1, 32'haaaa0001),
            fwd(1, 0, 1, 32'hbbbb0001), 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_ADDU, 3, 1, 0, 32'haaaa0001, rv(2), 0, 0));
    add_row("fwd mem only", r_type(1, 2, 3, 0, FN_ADDU), PC0, fwd(0, 0, 2, 32'h99990002),
            fwd(1, 0, 2, 32'hcccc0002), 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_ADDU, 3, 1, 0, rv(1), 32'hcccc0002, 0, 0));
    add_row("fwd mismatch", r_type(1, 2, 3, 0, FN_ADDU), PC0, fwd(1, 0, 5, 32'h12345678),
            NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_ADDU, 3, 1, 0, rv(1), rv(2), 0, 0));
    add_row("sw fwd din", i_type(OPC_SW, 1, 2, 8), PC0, fwd(1, 0, 2, 32'hdddd0002), NO_FWD,
            0, 0, JS_SEQ, 0, 0,
            2'b11, mk_exe(ALU_ARITH, OP_SW, 2, 0, 0, rv(1), 8, 32'hdddd0002, 0));
    add_row("lw", i_type(OPC_LW, 1, 5, 4), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 0, 0,
            2'b10, mk_exe(ALU_ARITH, OP_LW, 5, 1, 1, rv(1), 4, 0, 0));
    add_row("load use exe", r_type(5, 6, 3, 0, FN_ADDU), PC0, fwd(1, 1, 5, 32'h5), NO_FWD,
            0, 1, JS_SEQ, 0, 0, 2'b11, '0);
    add_row("load use mem", r_type(1, 6, 3, 0, FN_ADDU), PC0, NO_FWD, fwd(1, 1, 6, 32'h6),
            0, 1, JS_SEQ, 0, 0, 2'b11, '0);
    add_row("beq taken", i_type(OPC_BEQ, 1, 1, 3), PC0, NO_FWD, NO_FWD, 0, 0, JS_BR, 2,
            32'h00400110, 2'b11, mk_exe(ALU_JUMP, OP_BEQ, 0, 0, 0, rv(1), rv(1), 0, 0));
    add_row("beq not taken", i_type(OPC_BEQ, 1, 2, 3), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 2,
            32'h00400110, 2'b11, mk_exe(ALU_JUMP, OP_BEQ, 0, 0, 0, rv(1), rv(2), 0, 0));
    add_row("bne taken back", i_type(OPC_BNE, 1, 2, 16'hfffe), PC0, NO_FWD, NO_FWD, 0, 0,
            JS_BR, 2, 32'h004000fc, 2'b11,
            mk_exe(ALU_JUMP, OP_BNE, 31, 0, 0, rv(1), rv(2), 0, 0));
    add_row("bne not taken", i_type(OPC_BNE, 1, 1, 3), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 2,
            32'h00400110, 2'b11, mk_exe(ALU_JUMP, OP_BNE, 0, 0, 0, rv(1), rv(1), 0, 0));
    add_row("bgtz taken", i_type(OPC_BGTZ, 1, 0, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_BR, 2,
            32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BGTZ, 0, 0, 0, rv(1), 0, 0, 0));
    add_row("bgtz not taken", i_type(OPC_BGTZ, 0, 0, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 2,
            32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BGTZ, 0, 0, 0, 0, 0, 0, 0));
    add_row("blez taken", i_type(OPC_BLEZ, 0, 0, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_BR, 2,
            32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BLEZ, 0, 0, 0, 0, 0, 0, 0));
    add_row("blez not taken", i_type(OPC_BLEZ, 1, 0, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ, 2,
            32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BLEZ, 0, 0, 0, rv(1), 0, 0, 0));
    add_row("bgez taken", i_type(OPC_REGIMM, 1, 1, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_BR, 2,
            32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BGEZ, 0, 0, 0, rv(1), 0, 0, 0));
    add_row("bgez not taken", i_type(OPC_REGIMM, 1, 1, 5), PC0, fwd(1, 0, 1, 32'h80000000),
            NO_FWD, 0, 0, JS_SEQ, 2, 32'h00400118,
            2'b10, mk_exe(ALU_JUMP, OP_BGEZ, 0, 0, 0, 32'h80000000, 0, 0, 0));
    add_row("bltz taken", i_type(OPC_REGIMM, 1, 0, 5), PC0, fwd(1, 0, 1, 32'h80000000),
            NO_FWD, 0, 0, JS_BR, 2, 32'h00400118,
            2'b10, mk_exe(ALU_JUMP, OP_BLTZ, 0, 0, 0, 32'h80000000, 0, 0, 0));
    add_row("bltz not taken", i_type(OPC_REGIMM, 1, 0, 5), PC0, NO_FWD, NO_FWD, 0, 0, JS_SEQ,
            2, 32'h00400118, 2'b10, mk_exe(ALU_JUMP, OP_BLTZ, 0, 0, 0, rv(1), 0, 0, 0));
    add_row("j", j_type(OPC_J, 32'h0100040), PC0, NO_FWD, NO_FWD, 0, 0, JS_ABS, 1,
            32'h00400100, 2'b00, mk_exe(ALU_JUMP, OP_J, 0, 0, 0, 0, 0, 0, 0));
    add_row("jal", j_type(OPC_JAL, 32'h0100040), PC0, NO_FWD, NO_FWD, 0, 0, JS_ABS, 1,
            32'h00400100, 2'b00, mk_exe(ALU_JUMP, OP_JAL, 31, 1, 0, 0, 0, 0, 32'h00400108));
    add_row("jr", r_type(1, 0, 0, 0, FN_JR), PC0, NO_FWD, NO_FWD, 0, 0, JS_REG, 3, rv(1),
            2'b10, mk_exe(ALU_JUMP, OP_JR, 0, 0, 0, rv(1), 0, 0, 0));
    add_row("jalr", r_type(1, 0, 31, 0, FN_JALR), PC0, NO_FWD, NO_FWD, 0, 0, JS_REG, 3, rv(1),
            2'b10, mk_exe(ALU_JUMP, OP_JALR, 31, 1, 0, rv(1), 0, 0, 32'h00400108));
    add_row("undecoded 3f", 32'hfc000000, PC0, NO_FWD, NO_FWD, 1, 0, JS_SEQ, 0, 0, 2'b00, '0);
    add_row("undecoded 30", 32'hc0000000, PC0, NO_FWD, NO_FWD, 1, 0, JS_SEQ, 0, 0, 2'b00, '0);
endtask

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] PC0 = 32'h00400100;
    localparam fwd_t NO_FWD = '0;

    typedef struct {
        string       name;
        logic [31:0] inst;
        logic [31:0] pc;
        fwd_t        exe_fwd;
        fwd_t        mem_fwd;
        bit          rnd;
        bit          stall;
        jump_sel_e   jtsel;
        int          asel;
        logic [31:0] aexp;
        logic [1:0]  rd_en;
        exe_bus_t    exp;
    } vec_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rd1;
    logic [31:0] rd2;
    fwd_t        exe_fwd;
    fwd_t        mem_fwd;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic        rreg1;
    logic        rreg2;
    exe_bus_t    exe;
    jump_sel_e   jtsel;
    logic [31:0] addr1;
    logic [31:0] addr2;
    logic [31:0] addr3;
    logic        stall;

    vec_t vecs[$];
    int   seed = 7;
    int   cycles = 0;
    int   cycle_limit = 1000;
    int   fails = 0;
    bit   row_bad;

    always #HALF_PERIOD clk = ~clk;

    // register file answers the address in every byte
    assign rd1 = {4{3'b000, ra1}};
    assign rd2 = {4{3'b000, ra2}};

    id_stage i_dut (
        .cpu_clk_i (clk),
        .arst_n_i  (arst_n),
        .id_pc_i   (pc),
        .id_inst_i (inst),
        .rd1_i     (rd1),
        .rd2_i     (rd2),
        .ra1_o     (ra1),
        .ra2_o     (ra2),
        .rreg1_o   (rreg1),
        .rreg2_o   (rreg2),
        .exe_fwd_i (exe_fwd),
        .mem_fwd_i (mem_fwd),
        .exe_o     (exe),
        .jtsel_o   (jtsel),
        .addr1_o   (addr1),
        .addr2_o   (addr2),
        .addr3_o   (addr3),
        .stall_o   (stall)
    );

    function automatic logic [31:0] rv(input int r);
        return {4{3'b000, r[4:0]}};
    endfunction

    function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
                                           input int sa, input funct_e fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sa[4:0], 6'(fn)};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input int rs, input int rt,
                                           input int imm);
        return {6'(op), rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] j_type(input opcode_e op, input int index);
        return {6'(op), index[25:0]};
    endfunction

    function automatic fwd_t fwd(input int w, input int m, input int wa, input logic [31:0] wd);
        fwd_t f;
        f.wreg = w[0];
        f.mreg = m[0];
        f.wa   = wa[4:0];
        f.wd   = wd;
        return f;
    endfunction

    function automatic exe_bus_t mk_exe(input alu_type_e at, input alu_op_e op, input int wa,
                                        input int wreg, input int mreg,
                                        input logic [31:0] s1, input logic [31:0] s2,
                                        input logic [31:0] din, input logic [31:0] ret);
        exe_bus_t e;
        e.alu_type = at;
        e.alu_op   = op;
        e.wa       = wa[4:0];
        e.wreg     = wreg[0];
        e.mreg     = mreg[0];
        e.src1     = s1;
        e.src2     = s2;
        e.din      = din;
        e.retaddr  = ret;
        return e;
    endfunction

    task automatic add_row(input string name, input logic [31:0] i, input logic [31:0] p,
                           input fwd_t ef, input fwd_t mf, input int rnd, input int st,
                           input jump_sel_e js, input int asel, input logic [31:0] aexp,
                           input logic [1:0] rr, input exe_bus_t exp);
        vec_t v;
        v.name    = name;
        v.inst    = i;
        v.pc      = p;
        v.exe_fwd = ef;
        v.mem_fwd = mf;
        v.rnd     = rnd[0];
        v.stall   = st[0];
        v.jtsel   = js;
        v.asel    = asel;
        v.aexp    = aexp;
        v.rd_en   = rr;
        v.exp     = exp;
        vecs.push_back(v);
    endtask

    `include "tb_vectors.svh"

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            row_bad = 1'b1;
        end
    endtask

    task automatic check_exe(input exe_bus_t e);
        check_val("alu_type", 32'(exe.alu_type), 32'(e.alu_type));
        check_val("alu_op", 32'(exe.alu_op), 32'(e.alu_op));
        check_val("wa", 32'(exe.wa), 32'(e.wa));
        check_val("wreg", 32'(exe.wreg), 32'(e.wreg));
        check_val("mreg", 32'(exe.mreg), 32'(e.mreg));
        check_val("src1", exe.src1, e.src1);
        check_val("src2", exe.src2, e.src2);
        check_val("din", exe.din, e.din);
        check_val("retaddr", exe.retaddr, e.retaddr);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        vec_t v;
        arst_n  = 1'b0;
        pc      = '0;
        inst    = 32'hfc000000;
        exe_fwd = NO_FWD;
        mem_fwd = NO_FWD;
        load_vectors();
        cycle_limit = vecs.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        // nothing has been clocked in yet
        row_bad = 1'b0;
        check_exe('0);
        check_val("stall", 32'(stall), 0);
        $display("test 0 reset: %s", row_bad ? "fail" : "ok");
        if (row_bad)
            fails++;
        for (int i = 0; i < vecs.size(); i++) begin
            @(negedge clk);
            v = vecs[i];
            if (v.rnd)
                v.inst[25:0] = 26'($random(seed));
            inst    = v.inst;
            pc      = v.pc;
            exe_fwd = v.exe_fwd;
            mem_fwd = v.mem_fwd;
            row_bad = 1'b0;
            #(HALF_PERIOD - 2);
            check_val("stall", 32'(stall), 32'(v.stall));
            check_val("rreg1", 32'(rreg1), 32'(v.rd_en[1]));
            check_val("rreg2", 32'(rreg2), 32'(v.rd_en[0]));
            check_val("jtsel", 32'(jtsel), 32'(v.jtsel));
            case (v.asel)
                1: check_val("addr1", addr1, v.aexp);
                2: check_val("addr2", addr2, v.aexp);
                3: check_val("addr3", addr3, v.aexp);
                default: ;
            endcase
            @(posedge clk);
            #1;
            check_exe(v.exp);
            $display("test %0d %s: %s", i + 1, v.name, row_bad ? "fail" : "ok");
            if (row_bad)
                fails++;
        end
        $display("%0d tests run, %0d failed", vecs.size() + 1, fails);
        if (fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tests
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/operand_select.sv
verilog/branch_unit.sv
verilog/id_exe_reg.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -o sim_id_stage

out=$(./obj_dir/sim_id_stage)
echo "$out"

# grep fails the script when the pass line is missing
echo "$out" | grep -q "^TESTS PASSED$"
